// ==== Bender.yml ====
package:
  name: otter_mem_sys

sources:
  - include_dirs:
      - .
    files:
      - otter_bus_pkg.sv
      - otter_fault_pkg.sv
      - bram.sv
      - memory.sv
      - load_align.sv
      - fault_regs.sv
      - otter_mem_sys.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_otter_mem_sys.sv

// ==== bram.sv ====
`timescale 1ns/1ps
`include "otter_mem_defs.svh"

module bram #(
    parameter int RAM_ADDR_WIDTH = `MEM_ADDR_WIDTH - 2,
    parameter int RAM_BUS_WIDTH  = `MEM_BUS_WIDTH
) (
    input  logic                       clk,
    input  logic                       rd,
    input  logic [RAM_BUS_WIDTH/8-1:0] we,
    input  logic [RAM_ADDR_WIDTH-1:0]  addr,
    input  logic [RAM_BUS_WIDTH-1:0]   data,
    output logic [RAM_BUS_WIDTH-1:0]   out
);

    // One enable per byte lane
    localparam int NUM_LANES = RAM_BUS_WIDTH / 8;
    localparam int DEPTH     = 2 ** RAM_ADDR_WIDTH;

    //////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////

    // Word array, contents undefined at power-up
    logic [RAM_BUS_WIDTH-1:0] mem [DEPTH];

    // Byte-lane writes
    // Each lane updates on the same edge that presents it
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < NUM_LANES; lane++) begin
            if (we[lane]) begin
                mem[addr][lane*8 +: 8] <= data[lane*8 +: 8];
            end
        end
    end

    //////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////

    // Registered output, one cycle latency
    // Loads only on rd, so the word holds between reads
    always_ff @(posedge clk) begin
        if (rd) begin
            out <= mem[addr];
        end
    end

endmodule

// ==== fault_regs.sv ====
`timescale 1ns/1ps

module fault_regs (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          rd,
    input  logic                          wr,
    input  logic [31:0]                   addr,
    input  logic                          error,
    input  otter_fault_pkg::fault_cause_e cause,
    input  logic                          fault_clear,
    output logic                          fault_valid,
    output logic [31:0]                   fault_addr,
    output otter_fault_pkg::fault_cause_e fault_cause,
    output logic                          fault_write,
    output logic [7:0]                    fault_count
);

    import otter_fault_pkg::*;

    // Counter stops here
    localparam logic [7:0] COUNT_MAX = 8'hFF;

    logic fault_taken;
    logic capture;

    // Only an access that is actually taken can fault
    assign fault_taken = (rd || wr) && error;
    // Empty capture slot, or one being cleared this edge
    assign capture     = fault_taken && (!fault_valid || fault_clear);

    //////////////////////////////////////////////////////////////////
    // First-fault capture and fault counter
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fault_valid <= 1'b0;
            fault_addr  <= '0;
            fault_cause <= FAULT_NONE;
            fault_write <= 1'b0;
            fault_count <= '0;
        end else begin
            // Sticky until cleared, later faults are only counted
            if (capture) begin
                fault_valid <= 1'b1;
                fault_addr  <= addr;
                fault_cause <= cause;
                fault_write <= wr;
            end else if (fault_clear) begin
                fault_valid <= 1'b0;
                fault_addr  <= '0;
                fault_cause <= FAULT_NONE;
                fault_write <= 1'b0;
            end
            // Clear wins, a coincident fault restarts at one
            if (fault_clear) begin
                fault_count <= fault_taken ? 8'd1 : 8'd0;
            end else if (fault_taken && fault_count != COUNT_MAX) begin
                fault_count <= fault_count + 8'd1;
            end
        end
    end

endmodule

// ==== load_align.sv ====
`timescale 1ns/1ps
`include "otter_mem_defs.svh"

module load_align (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        rd,
    input  logic [1:0]                  addr_low,
    input  otter_bus_pkg::access_size_e size,
    input  logic                        load_unsigned,
    input  logic                        error,
    input  logic [`MEM_BUS_WIDTH-1:0]   rdata_raw,
    output logic [`MEM_BUS_WIDTH-1:0]   rdata
);

    import otter_bus_pkg::*;

    // Attributes of the read in flight
    access_size_e              size_q;
    logic [1:0]                addr_low_q;
    logic                      unsigned_q;
    logic                      error_q;
    // Addressed lanes moved down to bit 0
    logic [`MEM_BUS_WIDTH-1:0] shifted;

    //////////////////////////////////////////////////////////////////
    // Read attribute stage, lines up with the RAM output register
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            error_q <= 1'b0;
        end else if (rd) begin
            error_q <= error;
        end
    end

    // Sampled with the same strobe as the RAM, so both hold together
    always_ff @(posedge clk) begin
        if (rd) begin
            size_q     <= size;
            addr_low_q <= addr_low;
            unsigned_q <= load_unsigned;
        end
    end

    //////////////////////////////////////////////////////////////////
    // Lane select and extension
    //////////////////////////////////////////////////////////////////

    assign shifted = rdata_raw >> {addr_low_q, 3'b000};

    always_comb begin
        case (size_q)
            BYTE: rdata = unsigned_q ? {{(`MEM_BUS_WIDTH-8){1'b0}}, shifted[7:0]}
                                     : {{(`MEM_BUS_WIDTH-8){shifted[7]}}, shifted[7:0]};
            HALF: rdata = unsigned_q ? {{(`MEM_BUS_WIDTH-16){1'b0}}, shifted[15:0]}
                                     : {{(`MEM_BUS_WIDTH-16){shifted[15]}}, shifted[15:0]};
            // Word loads pass straight through
            default: rdata = rdata_raw;
        endcase
        // Faulting read returns zero
        if (error_q) rdata = '0;
    end

endmodule

// ==== memory.sv ====
`timescale 1ns/1ps
`include "otter_mem_defs.svh"

module memory (
    input  logic                          clk,
    input  logic                          rd,
    input  logic                          wr,
    input  logic [31:0]                   addr,
    input  otter_bus_pkg::access_size_e   size,
    input  logic [`MEM_BUS_WIDTH-1:0]     wdata,
    output logic [`MEM_BUS_WIDTH-1:0]     rdata_raw,
    output logic                          error,
    output otter_fault_pkg::fault_cause_e cause
);

    import otter_bus_pkg::*;
    import otter_fault_pkg::*;

    localparam int          RAM_ADDR_WIDTH = `MEM_ADDR_WIDTH - 2;
    localparam int          NUM_LANES      = `MEM_BUS_WIDTH / 8;
    // Highest legal byte address
    localparam logic [31:0] MAX_ADDR       = (32'd1 << `MEM_ADDR_WIDTH) - 32'd1;

    logic [RAM_ADDR_WIDTH-1:0] word_idx;
    logic [NUM_LANES-1:0]      lane_we;
    logic [`MEM_BUS_WIDTH-1:0] lane_data;
    logic [1:0]                byte_sel;

    assign word_idx = addr[`MEM_ADDR_WIDTH-1:2];
    assign byte_sel = addr[1:0];

    //////////////////////////////////////////////////////////////////
    // Access check
    //////////////////////////////////////////////////////////////////

    // Priority: range, then reserved size, then alignment
    always_comb begin
        cause = FAULT_NONE;
        if (addr > MAX_ADDR) begin
            cause = FAULT_RANGE;
        end else begin
            case (size)
                BYTE:    cause = FAULT_NONE;
                // Halfword needs bit 0 clear
                HALF:    if (addr[0]) cause = FAULT_MISALIGN;
                WORD:    if (byte_sel != 2'b00) cause = FAULT_MISALIGN;
                default: cause = FAULT_SIZE;
            endcase
        end
    end

    // Raised for any cause, same cycle
    assign error = (cause != FAULT_NONE);

    //////////////////////////////////////////////////////////////////
    // Store path
    //////////////////////////////////////////////////////////////////

    // Lane enables, all dropped on a faulty access
    always_comb begin
        lane_we = '0;
        if (wr && !error) begin
            case (size)
                BYTE:    lane_we[byte_sel] = 1'b1;
                HALF:    lane_we[byte_sel +: 2] = 2'b11;
                WORD:    lane_we = '1;
                default: lane_we = '0;
            endcase
        end
    end

    // Copy the low byte or halfword into every lane
    // so whichever lane is enabled sees the right data
    always_comb begin
        case (size)
            BYTE:    lane_data = {NUM_LANES{wdata[7:0]}};
            HALF:    lane_data = {(NUM_LANES/2){wdata[15:0]}};
            default: lane_data = wdata;
        endcase
    end

    bram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH),
        .RAM_BUS_WIDTH  (`MEM_BUS_WIDTH)
    ) ram (
        .clk  (clk),
        .rd   (rd),
        .we   (lane_we),
        .addr (word_idx),
        .data (lane_data),
        .out  (rdata_raw)
    );

endmodule

// ==== otter_bus_pkg.sv ====
package otter_bus_pkg;

    //////////////////////////////////////////////////////////////////
    // CPU-side port encodings
    //////////////////////////////////////////////////////////////////

    // Access size, taken from funct3[1:0] of the load/store
    // Code 2'b11 is reserved and flagged as a size fault
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } access_size_e;

endpackage

// ==== otter_fault_pkg.sv ====
package otter_fault_pkg;

    //////////////////////////////////////////////////////////////////
    // Fault causes reported by the memory check
    //////////////////////////////////////////////////////////////////

    // Listed here in encoding order, not priority order
    typedef enum logic [1:0] {
        FAULT_NONE     = 2'd0,
        FAULT_RANGE    = 2'd1,
        FAULT_MISALIGN = 2'd2,
        FAULT_SIZE     = 2'd3
    } fault_cause_e;

endpackage

// ==== otter_mem_defs.svh ====
`ifndef OTTER_MEM_DEFS_SVH
`define OTTER_MEM_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Data memory geometry
//////////////////////////////////////////////////////////////////////

// Byte address bits decoded by the data memory
// 2^15 bytes, so 32 KiB of RAM
`define MEM_ADDR_WIDTH 15

// Width of the CPU data port and of one RAM word
`define MEM_BUS_WIDTH 32

`endif

// ==== otter_mem_sys.f ====
+incdir+.
otter_bus_pkg.sv
otter_fault_pkg.sv
bram.sv
memory.sv
load_align.sv
fault_regs.sv
otter_mem_sys.sv
tb_otter_mem_sys.sv

// ==== otter_mem_sys.sv ====
`timescale 1ns/1ps
`include "otter_mem_defs.svh"

module otter_mem_sys (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          rd,
    input  logic                          wr,
    input  logic [31:0]                   addr,
    input  otter_bus_pkg::access_size_e   size,
    input  logic                          load_unsigned,
    input  logic [`MEM_BUS_WIDTH-1:0]     wdata,
    input  logic                          fault_clear,
    output logic [`MEM_BUS_WIDTH-1:0]     rdata,
    output logic                          error,
    output logic                          fault_valid,
    output logic [31:0]                   fault_addr,
    output otter_fault_pkg::fault_cause_e fault_cause,
    output logic                          fault_write,
    output logic [7:0]                    fault_count
);

    import otter_fault_pkg::*;

    // Raw RAM word, before lane select
    logic [`MEM_BUS_WIDTH-1:0] rdata_raw;
    // Combinational cause from the check
    fault_cause_e              cause;

    //////////////////////////////////////////////////////////////////
    // Check, store path and RAM
    //////////////////////////////////////////////////////////////////

    memory u_memory (
        .clk       (clk),
        .rd        (rd),
        .wr        (wr),
        .addr      (addr),
        .size      (size),
        .wdata     (wdata),
        .rdata_raw (rdata_raw),
        .error     (error),
        .cause     (cause)
    );

    // Load data path
    load_align u_load_align (
        .clk           (clk),
        .arst_n        (arst_n),
        .rd            (rd),
        .addr_low      (addr[1:0]),
        .size          (size),
        .load_unsigned (load_unsigned),
        .error         (error),
        .rdata_raw     (rdata_raw),
        .rdata         (rdata)
    );

    // Fault status beside the check logic
    fault_regs u_fault_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .rd          (rd),
        .wr          (wr),
        .addr        (addr),
        .error       (error),
        .cause       (cause),
        .fault_clear (fault_clear),
        .fault_valid (fault_valid),
        .fault_addr  (fault_addr),
        .fault_cause (fault_cause),
        .fault_write (fault_write),
        .fault_count (fault_count)
    );

endmodule

// ==== tb_otter_mem_sys.sv ====
`timescale 1ns/1ps
`include "otter_mem_defs.svh"

module tb_otter_mem_sys;

    import otter_bus_pkg::*;
    import otter_fault_pkg::*;

    // Cycles any single wait may take
    localparam int TIMEOUT = 20;

    logic         clk = 1'b0;
    logic         arst_n;
    logic         rd;
    logic         wr;
    logic [31:0]  addr;
    access_size_e size;
    logic         load_unsigned;
    logic [31:0]  wdata;
    logic         fault_clear;
    logic [31:0]  rdata;
    logic         error;
    logic         fault_valid;
    logic [31:0]  fault_addr;
    fault_cause_e fault_cause;
    logic         fault_write;
    logic [7:0]   fault_count;

    // Byte model of the first 1 KiB
    logic [7:0]   model_mem [1024];
    // Expected rdata for the next cycle
    logic [31:0]  exp_q [$];
    // Result of the last read, held until the next one
    logic [31:0]  last_rdata;
    logic         have_rdata = 1'b0;
    // Fault register model
    logic         m_valid;
    logic [31:0]  m_addr;
    fault_cause_e m_cause;
    logic         m_write;
    logic [7:0]   m_count;
    string        test_name;

    otter_mem_sys DUT (.*);

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Priority order is range before reserved size before alignment
    function automatic fault_cause_e cause_of(logic [31:0] a, logic [1:0] s);
        if (a >= (32'd1 << `MEM_ADDR_WIDTH)) return FAULT_RANGE;
        if (s == 2'd3) return FAULT_SIZE;
        if ((s == 2'd2 && a[1:0] != 2'b00) || (s == 2'd1 && a[0])) return FAULT_MISALIGN;
        return FAULT_NONE;
    endfunction

    function automatic logic [31:0] load_value(logic [31:0] a, logic [1:0] s, logic u);
        logic [7:0]  b;
        logic [15:0] h;
        b = model_mem[a[9:0]];
        h = {model_mem[a[9:0] + 10'd1], model_mem[a[9:0]]};
        case (s)
            2'd0:    return u ? {24'd0, b} : {{24{b[7]}}, b};
            2'd1:    return u ? {16'd0, h} : {{16{h[15]}}, h};
            default: return {model_mem[{a[9:2], 2'd3}], model_mem[{a[9:2], 2'd2}],
                             model_mem[{a[9:2], 2'd1}], model_mem[{a[9:2], 2'd0}]};
        endcase
    endfunction

    // 1, 2 or 4 bytes from the low end of the store data
    task automatic store_model(logic [31:0] a, logic [1:0] s, logic [31:0] d);
        for (int i = 0; i < (1 << s); i++) begin
            model_mem[a[9:0] + i] = d[i*8 +: 8];
        end
    endtask

    task automatic report_mismatch(string what, logic [31:0] expected, logic [31:0] actual);
        $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
        $display("Testbench failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else report_mismatch(what, expected, actual);
    endtask

    // Combinational error on inputs held since the falling edge
    always @(posedge clk) begin
        fault_cause_e c;
        logic         taken;
        if (arst_n) begin
            c = cause_of(addr, size);
            taken = (rd || wr) && (c != FAULT_NONE);
            check_value("error", 32'(c != FAULT_NONE), 32'(error));
            if (rd) exp_q.push_back(taken ? 32'd0 : load_value(addr, size, load_unsigned));
            if (wr && c == FAULT_NONE) store_model(addr, size, wdata);
            if (fault_clear || (taken && !m_valid)) begin
                m_valid = taken;
                m_addr  = taken ? addr : 32'd0;
                m_cause = taken ? c : FAULT_NONE;
                m_write = taken ? wr : 1'b0;
            end
            if (fault_clear) m_count = taken ? 8'd1 : 8'd0;
            else if (taken && m_count != 8'hFF) m_count = m_count + 8'd1;
        end
    end

    // Registered outputs compared mid-cycle
    always @(negedge clk) begin
        if (arst_n) begin
            if (exp_q.size() > 0) begin
                last_rdata = exp_q.pop_front();
                have_rdata = 1'b1;
            end
            // Between reads the previous result stays on rdata
            if (have_rdata) check_value("rdata", last_rdata, rdata);
            check_value("fault_valid", 32'(m_valid), 32'(fault_valid));
            check_value("fault_addr", m_addr, fault_addr);
            check_value("fault_cause", 32'(m_cause), 32'(fault_cause));
            check_value("fault_write", 32'(m_write), 32'(fault_write));
            check_value("fault_count", 32'(m_count), 32'(fault_count));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic drive(logic r, logic w, logic [31:0] a, logic [1:0] s, logic u,
                         logic [31:0] d, logic clr);
        @(negedge clk);
        rd            = r;
        wr            = w;
        addr          = a;
        size          = access_size_e'(s);
        load_unsigned = u;
        wdata         = d;
        fault_clear   = clr;
    endtask

    task automatic idle(logic clr);
        drive(1'b0, 1'b0, 32'd0, 2'd2, 1'b0, 32'd0, clr);
    endtask

    task automatic wait_fault_valid(logic level);
        int n;
        n = 0;
        while (fault_valid !== level) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("Timed out waiting for fault_valid to become %0b", level);
                $display("Testbench failed");
                $fatal(1, "timeout");
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] waddr [8];
        int          seed_ret;
        seed_ret = $urandom(5);
        {rd, wr, load_unsigned, fault_clear} = '0;
        addr = '0;
        size = WORD;
        wdata = '0;
        {m_valid, m_addr, m_write, m_count} = '0;
        m_cause = FAULT_NONE;
        test_name = "reset";
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk) arst_n = 1'b1;

        // Random words then back-to-back reads
        test_name = "word_rw";
        foreach (waddr[i]) begin
            waddr[i] = ($urandom % 256) << 2;
            drive(1'b0, 1'b1, waddr[i], 2'd2, 1'b0, $urandom, 1'b0);
        end
        foreach (waddr[i]) drive(1'b1, 1'b0, waddr[i], 2'd2, 1'b0, 32'd0, 1'b0);

        // Bytes into 0x100 and halves into 0x104 before every legal load
        test_name = "byte_half";
        drive(1'b0, 1'b1, 32'h100, 2'd2, 1'b0, $urandom, 1'b0);
        drive(1'b0, 1'b1, 32'h104, 2'd2, 1'b0, $urandom, 1'b0);
        for (int off = 0; off < 4; off++) begin
            drive(1'b0, 1'b1, 32'h100 + off, 2'd0, 1'b0, $urandom, 1'b0);
            drive(1'b1, 1'b0, 32'h100, 2'd2, 1'b0, 32'd0, 1'b0);
        end
        for (int off = 0; off < 4; off += 2) begin
            drive(1'b0, 1'b1, 32'h104 + off, 2'd1, 1'b0, $urandom, 1'b0);
            drive(1'b1, 1'b0, 32'h104, 2'd2, 1'b0, 32'd0, 1'b0);
        end
        for (int off = 0; off < 8; off++) begin
            for (int u = 0; u < 2; u++) begin
                drive(1'b1, 1'b0, 32'h100 + off, 2'd0, u[0], 32'd0, 1'b0);
                if (off[0] == 1'b0) drive(1'b1, 1'b0, 32'h100 + off, 2'd1, u[0], 32'd0, 1'b0);
            end
        end

        // Misaligned and reserved-size accesses
        test_name = "misalign";
        drive(1'b0, 1'b1, 32'h200, 2'd2, 1'b0, $urandom, 1'b0);
        drive(1'b0, 1'b1, 32'h201, 2'd2, 1'b0, $urandom, 1'b0);
        drive(1'b0, 1'b1, 32'h203, 2'd1, 1'b0, $urandom, 1'b0);
        drive(1'b0, 1'b1, 32'h200, 2'd3, 1'b0, $urandom, 1'b0);
        drive(1'b1, 1'b0, 32'h200, 2'd2, 1'b0, 32'd0, 1'b0);
        drive(1'b1, 1'b0, 32'h201, 2'd1, 1'b0, 32'd0, 1'b0);
        drive(1'b1, 1'b0, 32'h200, 2'd3, 1'b0, 32'd0, 1'b0);

        // Out-of-range aliases of 0x200 must leave it untouched
        test_name = "range";
        idle(1'b1);
        idle(1'b0);
        wait_fault_valid(1'b0);
        drive(1'b0, 1'b1, 32'h0000_8200, 2'd2, 1'b0, $urandom, 1'b0);
        drive(1'b0, 1'b1, 32'h8000_0200, 2'd0, 1'b0, $urandom, 1'b0);
        drive(1'b1, 1'b0, 32'h200, 2'd2, 1'b0, 32'd0, 1'b0);
        idle(1'b0);
        wait_fault_valid(1'b1);
        check_value("range cause", 32'(FAULT_RANGE), 32'(fault_cause));

        // First fault sticks while every fault counts
        test_name = "fault_capture";
        idle(1'b1);
        idle(1'b0);
        wait_fault_valid(1'b0);
        // Faulty address with no strobe is not an access
        drive(1'b0, 1'b0, 32'h303, 2'd1, 1'b0, 32'd0, 1'b0);
        drive(1'b1, 1'b0, 32'h301, 2'd1, 1'b0, 32'd0, 1'b0);
        drive(1'b0, 1'b1, 32'h9000, 2'd2, 1'b0, $urandom, 1'b0);
        drive(1'b1, 1'b0, 32'h300, 2'd3, 1'b0, 32'd0, 1'b0);
        idle(1'b0);
        wait_fault_valid(1'b1);
        check_value("first addr", 32'h301, fault_addr);
        check_value("first write", 32'd0, 32'(fault_write));
        check_value("count", 32'd3, 32'(fault_count));
        idle(1'b1);
        idle(1'b0);
        wait_fault_valid(1'b0);
        check_value("cleared count", 32'd0, 32'(fault_count));
        // Clear and a new fault on one edge
        drive(1'b0, 1'b1, 32'h305, 2'd2, 1'b0, $urandom, 1'b1);
        idle(1'b0);
        wait_fault_valid(1'b1);
        check_value("clear+fault addr", 32'h305, fault_addr);
        check_value("clear+fault count", 32'd1, 32'(fault_count));

        // Counter stops at its maximum
        test_name = "saturate";
        repeat (260) drive(1'b0, 1'b1, 32'h305, 2'd2, 1'b0, $urandom, 1'b0);
        idle(1'b0);
        check_value("saturated count", 32'd255, 32'(fault_count));
        idle(1'b0);
        idle(1'b0);

        if (exp_q.size() != 0) begin
            $display("Expected read data was left unchecked at the end of the run");
            $display("Testbench failed");
            $fatal(1, "unchecked reads");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule
